// File: compile.f
+incdir+include
src/rename_pkg.sv
src/tag_free_list.sv
src/rat_map_table.sv
src/rename_bypass.sv
src/register_rename.sv
tb/tb_register_rename.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --timing -Wno-fatal
TOP      = tb_register_rename
RTL_TOP  = register_rename
FILELIST = compile.f
OBJ_DIR  = obj_dir
PASS_MSG = Simulation PASSED

.PHONY: all lint sim clean

all: sim

# Lint the design on its own, then with the testbench
lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(RTL_TOP) -Iinclude \
		src/rename_pkg.sv src/tag_free_list.sv src/rat_map_table.sv \
		src/rename_bypass.sv src/register_rename.sv
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb/tb_register_rename.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_macros.svh"

module tb_register_rename;

    import rename_pkg::*;

    localparam int NUM_CYCLES = 3000;
    localparam int WAIT_LIMIT = 200;

    logic                     clk;
    logic                     reset;
    logic                     flush_i;
    decode_group_t            decode_i;
    commit_group_t            commit_i;
    rename_group_t            rename_o;
    logic [`RENAME_WIDTH-1:0] rename_ready_o;

    // Reference table and free list
    logic [`PHYS_AW-1:0] ref_map [`ARCH_REGS];
    logic [`ROB_AW-1:0]  ref_free [$];
    // Issued entries in age order, destination above the ROB index
    logic [`ARCH_AW+`ROB_AW-1:0] inflight [$];
    logic [31:0] rng_state;

    register_rename u_register_rename (
        .clk            (clk),
        .reset          (reset),
        .flush_i        (flush_i),
        .decode_i       (decode_i),
        .commit_i       (commit_i),
        .rename_o       (rename_o),
        .rename_ready_o (rename_ready_o)
    );

    always #10 clk = ~clk;

    // ======================================================================
    // Helpers
    // ======================================================================
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Low registers half the time, so groups chain and hit x0 often
    function automatic logic [`ARCH_AW-1:0] pick_reg();
        logic [31:0] r;
        r = next_rand();
        return r[31] ? `ARCH_AW'(r[2:0]) : r[`ARCH_AW-1:0];
    endfunction

    function automatic decode_group_t random_group();
        decode_group_t g;
        for (int k = 0; k < `RENAME_WIDTH; k++) begin
            g[k].valid = (next_rand() % 4) != 0;
            g[k].rs1   = pick_reg();
            g[k].rs2   = pick_reg();
            g[k].rd    = pick_reg();
            g[k].rd_we = (next_rand() % 5) != 0;
        end
        return g;
    endfunction

    // Thermometer of the free count, capped at three
    function automatic logic [`RENAME_WIDTH-1:0] ready_mask(input int free_cnt);
        if (free_cnt >= 3) begin
            return 3'b111;
        end else if (free_cnt == 2) begin
            return 3'b011;
        end else if (free_cnt == 1) begin
            return 3'b001;
        end
        return 3'b000;
    endfunction

    // Newest older accepted writer of areg, else the table before this edge
    function automatic logic [`PHYS_AW-1:0] expected_source(
        input decode_group_t                          dec,
        input logic [`RENAME_WIDTH-1:0]               acc,
        input logic [`RENAME_WIDTH-1:0][`PHYS_AW-1:0] tags,
        input int                                     slot,
        input logic [`ARCH_AW-1:0]                    areg
    );
        for (int j = slot - 1; j >= 0; j--) begin
            if (acc[j] && dec[j].rd_we && (dec[j].rd != '0) && (dec[j].rd == areg)) begin
                return tags[j];
            end
        end
        return ref_map[areg];
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Identity map, full free list 0..31, nothing in flight
    task automatic reset_model();
        for (int i = 0; i < `ARCH_REGS; i++) begin
            ref_map[i] = `PHYS_AW'(i);
        end
        ref_free.delete();
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            ref_free.push_back(`ROB_AW'(i));
        end
        inflight.delete();
    endtask

    // ======================================================================
    // One cycle of drive, check and model update
    // ======================================================================
    task automatic step(input decode_group_t dec, input int n_commit, input logic flush);
        commit_group_t                          com;
        rename_slot_t                           want;
        logic [`RENAME_WIDTH-1:0]               acc;
        logic [`RENAME_WIDTH-1:0][`PHYS_AW-1:0] tags;
        logic [`ARCH_AW+`ROB_AW-1:0]            ent;
        logic [`ARCH_AW-1:0]                    dest;
        logic [`ROB_AW-1:0]                     idx;
        int n;
        int free_cnt;
        int nvalid;
        // Oldest in-flight entries retire first
        n = (n_commit < inflight.size()) ? n_commit : inflight.size();
        com = '0;
        for (int k = 0; k < n; k++) begin
            com[k].valid   = 1'b1;
            com[k].arch    = inflight[k][`ROB_AW+:`ARCH_AW];
            com[k].rob_idx = inflight[k][`ROB_AW-1:0];
        end
        @(negedge clk);
        flush_i  = flush;
        decode_i = dec;
        commit_i = com;
        #2;
        // A flush cycle accepts nothing
        free_cnt = flush ? 0 : ref_free.size();
        check_equal(rename_ready_o, ready_mask(free_cnt), "rename_ready_o");
        nvalid = 0;
        acc    = '0;
        tags   = '0;
        for (int k = 0; k < `RENAME_WIDTH; k++) begin
            want = '0;
            nvalid += int'(dec[k].valid);
            if (dec[k].valid && (nvalid <= free_cnt)) begin
                acc[k]           = 1'b1;
                tags[k]          = `PHYS_AW'(`ROB_TAG_BASE + ref_free[nvalid-1]);
                want.valid       = 1'b1;
                want.rd_phys     = tags[k];
                want.rs1_phys    = expected_source(dec, acc, tags, k, dec[k].rs1);
                want.rs2_phys    = expected_source(dec, acc, tags, k, dec[k].rs2);
                want.old_rd_phys = expected_source(dec, acc, tags, k, dec[k].rd);
            end
            check_equal(rename_o[k].valid, want.valid, $sformatf("slot %0d valid", k));
            check_equal(rename_o[k].rs1_phys, want.rs1_phys, $sformatf("slot %0d rs1", k));
            check_equal(rename_o[k].rs2_phys, want.rs2_phys, $sformatf("slot %0d rs2", k));
            check_equal(rename_o[k].rd_phys, want.rd_phys, $sformatf("slot %0d rd", k));
            check_equal(rename_o[k].old_rd_phys, want.old_rd_phys,
                        $sformatf("slot %0d old rd", k));
        end
        if (flush) begin
            reset_model();
        end else begin
            // Commit restores first so that a same-edge rename overrides them
            for (int k = 0; k < n; k++) begin
                ent  = inflight.pop_front();
                idx  = ent[`ROB_AW-1:0];
                dest = ent[`ROB_AW+:`ARCH_AW];
                ref_free.push_back(idx);
                if ((dest != '0) && (ref_map[dest]
                        == `PHYS_AW'(`ROB_TAG_BASE + idx))) begin
                    ref_map[dest] = {1'b0, dest};
                end
            end
            for (int k = 0; k < `RENAME_WIDTH; k++) begin
                if (acc[k]) begin
                    idx  = ref_free.pop_front();
                    dest = dec[k].rd_we ? dec[k].rd : '0;
                    inflight.push_back({dest, idx});
                    if (dec[k].rd_we && (dec[k].rd != '0)) begin
                        ref_map[dec[k].rd] = tags[k];
                    end
                end
            end
        end
    endtask

    // Four groups that look up every register once
    task automatic read_all();
        decode_group_t g;
        for (int base = 0; base < `ARCH_REGS; base += 9) begin
            g = '0;
            for (int k = 0; k < `RENAME_WIDTH; k++) begin
                g[k].valid = 1'b1;
                g[k].rs1   = `ARCH_AW'(base + 3 * k);
                g[k].rs2   = `ARCH_AW'(base + 3 * k + 1);
                g[k].rd    = `ARCH_AW'(base + 3 * k + 2);
            end
            step(g, 0, 1'b0);
        end
    endtask

    task automatic wait_ready();
        int guard;
        guard = 0;
        while (rename_ready_o !== 3'b111) begin
            if (guard == WAIT_LIMIT) begin
                $display("Rename stage did not become ready after reset");
                $display("Simulation FAILED");
                $fatal(1, "ready timeout");
            end
            @(negedge clk);
            guard++;
        end
    endtask

    // Retire everything in flight, three per cycle
    task automatic drain();
        int guard;
        guard = 0;
        while (inflight.size() != 0) begin
            if (guard == WAIT_LIMIT) begin
                $display("In-flight entries did not retire in time");
                $display("Simulation FAILED");
                $fatal(1, "drain timeout");
            end
            step('0, 3, 1'b0);
            guard++;
        end
    endtask

    // ======================================================================
    // Sequence
    // ======================================================================
    initial begin
        int n;
        clk       = 1'b0;
        reset     = 1'b0;
        flush_i   = 1'b0;
        decode_i  = '0;
        commit_i  = '0;
        rng_state = 32'h29a7_0332;
        reset_model();
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        wait_ready();
        read_all();
        // Commit rate per phase is random, none or three
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            case ((cyc / 60) % 3)
                0: n = int'(next_rand() % 4);
                1: n = 0;
                default: n = 3;
            endcase
            step(random_group(), n, (next_rand() % 113) == 0);
        end
        drain();
        read_all();
        // Starve commits so the map holds ROB tags and the list runs dry
        for (int i = 0; i < 12; i++) begin
            step(random_group(), 0, 1'b0);
        end
        // Flush with renames and commits pending
        step(random_group(), 2, 1'b1);
        // Identity map and full ready in the cycle after the flush
        read_all();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/register_rename.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_macros.svh"

module register_rename (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           flush_i,
    input  rename_pkg::decode_group_t      decode_i,
    input  rename_pkg::commit_group_t      commit_i,
    output rename_pkg::rename_group_t      rename_o,
    output logic [`RENAME_WIDTH-1:0]       rename_ready_o
);

    // ======================================================================
    // Internal nets
    // ======================================================================

    // Valid bits pulled out of the decode group
    logic [`RENAME_WIDTH-1:0]               decode_valid;

    // Free list to table and bypass
    logic [`RENAME_WIDTH-1:0]               grant;
    logic [`RENAME_WIDTH-1:0][`PHYS_AW-1:0] grant_tag;

    // Table lookups, one per slot and operand
    logic [`RENAME_WIDTH-1:0][`PHYS_AW-1:0] rs1_map;
    logic [`RENAME_WIDTH-1:0][`PHYS_AW-1:0] rs2_map;
    logic [`RENAME_WIDTH-1:0][`PHYS_AW-1:0] rd_map;

    for (genvar k = 0; k < `RENAME_WIDTH; k++) begin : g_valid
        assign decode_valid[k] = decode_i[k].valid;
    end

    // ======================================================================
    // ROB entry free list
    // ======================================================================

    // Every valid slot takes one entry, in slot order
    tag_free_list u_free_list (
        .clk            (clk),
        .reset          (reset),
        .flush_i        (flush_i),
        .decode_valid_i (decode_valid),
        .commit_i       (commit_i),
        .grant_o        (grant),
        .grant_tag_o    (grant_tag),
        .ready_o        (rename_ready_o)
    );

    // ======================================================================
    // Alias table
    // ======================================================================

    // Registered lookups, update on the next edge
    rat_map_table u_map_table (
        .clk         (clk),
        .reset       (reset),
        .flush_i     (flush_i),
        .decode_i    (decode_i),
        .grant_i     (grant),
        .grant_tag_i (grant_tag),
        .commit_i    (commit_i),
        .rs1_map_o   (rs1_map),
        .rs2_map_o   (rs2_map),
        .rd_map_o    (rd_map)
    );

    // ======================================================================
    // Same-group forwarding
    // ======================================================================

    // Combinational result, zero latency from decode
    rename_bypass u_bypass (
        .decode_i    (decode_i),
        .grant_i     (grant),
        .grant_tag_i (grant_tag),
        .rs1_map_i   (rs1_map),
        .rs2_map_i   (rs2_map),
        .rd_map_i    (rd_map),
        .rename_o    (rename_o)
    );

endmodule

`default_nettype wire

// File: src/rename_bypass.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_macros.svh"

module rename_bypass (
    input  rename_pkg::decode_group_t                 decode_i,
    input  logic [`RENAME_WIDTH-1:0]                  grant_i,
    input  logic [`RENAME_WIDTH-1:0][`PHYS_AW-1:0]    grant_tag_i,
    input  logic [`RENAME_WIDTH-1:0][`PHYS_AW-1:0]    rs1_map_i,
    input  logic [`RENAME_WIDTH-1:0][`PHYS_AW-1:0]    rs2_map_i,
    input  logic [`RENAME_WIDTH-1:0][`PHYS_AW-1:0]    rd_map_i,
    output rename_pkg::rename_group_t                 rename_o
);

    import rename_pkg::*;

    // Older slots that will write a real register this cycle
    logic [`RENAME_WIDTH-1:0] writer;

    // Youngest older writer of areg wins, otherwise the table tag
    function automatic logic [`PHYS_AW-1:0] resolve_tag(
        input decode_group_t                        dec,
        input logic [`RENAME_WIDTH-1:0]             writes,
        input logic [`RENAME_WIDTH-1:0][`PHYS_AW-1:0] tags,
        input int                                   slot,
        input logic [`ARCH_AW-1:0]                  areg,
        input logic [`PHYS_AW-1:0]                  table_tag
    );
        logic [`PHYS_AW-1:0] tag;
        tag = table_tag;
        // Ascending scan leaves the newest match
        for (int j = 0; j < `RENAME_WIDTH; j++) begin
            if ((j < slot) && writes[j] && (dec[j].rd == areg)) begin
                tag = tags[j];
            end
        end
        return tag;
    endfunction

    // ======================================================================
    // Writer mask
    // ======================================================================
    always_comb begin
        for (int k = 0; k < `RENAME_WIDTH; k++) begin
            // x0 is never a forwarding source
            writer[k] = grant_i[k] && decode_i[k].rd_we && (decode_i[k].rd != '0);
        end
    end

    // ======================================================================
    // Result assembly
    // ======================================================================
    always_comb begin
        for (int k = 0; k < `RENAME_WIDTH; k++) begin
            // Not accepted, all fields zero
            rename_o[k] = '0;
            if (grant_i[k]) begin
                rename_o[k].valid       = 1'b1;
                rename_o[k].rs1_phys    = resolve_tag(decode_i, writer, grant_tag_i, k,
                                                      decode_i[k].rs1, rs1_map_i[k]);
                rename_o[k].rs2_phys    = resolve_tag(decode_i, writer, grant_tag_i, k,
                                                      decode_i[k].rs2, rs2_map_i[k]);
                rename_o[k].rd_phys     = grant_tag_i[k];
                // Previous owner of rd, may be an older slot in this group
                rename_o[k].old_rd_phys = resolve_tag(decode_i, writer, grant_tag_i, k,
                                                      decode_i[k].rd, rd_map_i[k]);
            end
        end
    end

endmodule

`default_nettype wire

// File: src/rat_map_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_macros.svh"

module rat_map_table (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      flush_i,
    input  rename_pkg::decode_group_t                 decode_i,
    input  logic [`RENAME_WIDTH-1:0]                  grant_i,
    input  logic [`RENAME_WIDTH-1:0][`PHYS_AW-1:0]    grant_tag_i,
    input  rename_pkg::commit_group_t                 commit_i,
    output logic [`RENAME_WIDTH-1:0][`PHYS_AW-1:0]    rs1_map_o,
    output logic [`RENAME_WIDTH-1:0][`PHYS_AW-1:0]    rs2_map_o,
    output logic [`RENAME_WIDTH-1:0][`PHYS_AW-1:0]    rd_map_o
);

    // Tag of ROB entry 0
    localparam logic [`PHYS_AW-1:0] TAG_BASE = `ROB_TAG_BASE;

    // Alias table, entry 0 is never written
    logic [`PHYS_AW-1:0] map_q [`ARCH_REGS];

    // Update requests for this cycle
    logic [`RENAME_WIDTH-1:0] commit_hit;
    logic [`RENAME_WIDTH-1:0] rename_we;

    // ======================================================================
    // Read ports
    // ======================================================================

    // Nine lookups from the registered table
    // Same-cycle commits are not forwarded here
    always_comb begin
        for (int k = 0; k < `RENAME_WIDTH; k++) begin
            rs1_map_o[k] = map_q[decode_i[k].rs1];
            rs2_map_o[k] = map_q[decode_i[k].rs2];
            rd_map_o[k]  = map_q[decode_i[k].rd];
        end
    end

    // ======================================================================
    // Update requests
    // ======================================================================
    always_comb begin
        for (int k = 0; k < `RENAME_WIDTH; k++) begin
            // Restore only if the committing entry is still the newest mapping
            commit_hit[k] = commit_i[k].valid
                         && (commit_i[k].arch != '0)
                         && (map_q[commit_i[k].arch]
                             == TAG_BASE + {1'b0, commit_i[k].rob_idx});
            // Accepted writers other than x0
            rename_we[k]  = grant_i[k]
                         && decode_i[k].rd_we
                         && (decode_i[k].rd != '0);
        end
    end

    // ======================================================================
    // Table update
    // ======================================================================

    // Commits first, then renames, so a newer rename overrides a restore
    // Within each pass the later slot wins
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_q[i] <= `PHYS_AW'(i);
            end
        end else if (flush_i) begin
            // Identity map, everything back in the register file
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_q[i] <= `PHYS_AW'(i);
            end
        end else begin
            for (int k = 0; k < `RENAME_WIDTH; k++) begin
                if (commit_hit[k]) begin
                    map_q[commit_i[k].arch] <= {1'b0, commit_i[k].arch};
                end
            end
            for (int k = 0; k < `RENAME_WIDTH; k++) begin
                if (rename_we[k]) begin
                    map_q[decode_i[k].rd] <= grant_tag_i[k];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/tag_free_list.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_macros.svh"

module tag_free_list (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      flush_i,
    input  logic [`RENAME_WIDTH-1:0]                  decode_valid_i,
    input  rename_pkg::commit_group_t                 commit_i,
    output logic [`RENAME_WIDTH-1:0]                  grant_o,
    output logic [`RENAME_WIDTH-1:0][`PHYS_AW-1:0]    grant_tag_o,
    output logic [`RENAME_WIDTH-1:0]                  ready_o
);

    // Tag of ROB entry 0
    localparam logic [`PHYS_AW-1:0] TAG_BASE = `ROB_TAG_BASE;

    // Circular list of free ROB entries
    logic [`ROB_AW-1:0] free_mem [`ROB_DEPTH];
    logic [`ROB_AW-1:0] head;
    logic [`ROB_AW-1:0] tail;
    logic [`CNT_W-1:0]  count;

    // Per-slot read and write addresses
    logic [`ROB_AW-1:0] rd_addr [`RENAME_WIDTH];
    logic [`ROB_AW-1:0] wr_addr [`RENAME_WIDTH];
    logic [`RENAME_WIDTH-1:0] wr_en;

    // Running totals for this cycle
    logic [`CNT_W-1:0] nvalid;
    logic [`CNT_W-1:0] grant_cnt;
    logic [`CNT_W-1:0] commit_cnt;

    // ======================================================================
    // In-order grant
    // ======================================================================
    always_comb begin
        nvalid      = '0;
        grant_cnt   = '0;
        grant_o     = '0;
        grant_tag_o = '0;
        for (int k = 0; k < `RENAME_WIDTH; k++) begin
            // Next entry after the ones already taken by older slots
            rd_addr[k] = head + grant_cnt[`ROB_AW-1:0];
            if (decode_valid_i[k] && !flush_i) begin
                nvalid = nvalid + `CNT_W'(1);
                // Accept while the valid slots so far still fit
                if (nvalid <= count) begin
                    grant_o[k]     = 1'b1;
                    grant_tag_o[k] = TAG_BASE + {1'b0, free_mem[rd_addr[k]]};
                    grant_cnt      = grant_cnt + `CNT_W'(1);
                end
            end
        end
    end

    // Thermometer of the free count, capped at group width
    always_comb begin
        if (flush_i) begin
            ready_o = '0;
        end else if (count >= `CNT_W'(`RENAME_WIDTH)) begin
            ready_o = 3'b111;
        end else if (count == `CNT_W'(2)) begin
            ready_o = 3'b011;
        end else if (count == `CNT_W'(1)) begin
            ready_o = 3'b001;
        end else begin
            ready_o = 3'b000;
        end
    end

    // ======================================================================
    // Commit return
    // ======================================================================
    always_comb begin
        commit_cnt = '0;
        for (int k = 0; k < `RENAME_WIDTH; k++) begin
            wr_addr[k] = tail + commit_cnt[`ROB_AW-1:0];
            wr_en[k]   = commit_i[k].valid && !flush_i;
            if (wr_en[k]) begin
                commit_cnt = commit_cnt + `CNT_W'(1);
            end
        end
    end

    // Storage refills with entries 0..31 in order on reset or flush
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                free_mem[i] <= `ROB_AW'(i);
            end
        end else if (flush_i) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                free_mem[i] <= `ROB_AW'(i);
            end
        end else begin
            for (int k = 0; k < `RENAME_WIDTH; k++) begin
                if (wr_en[k]) begin
                    free_mem[wr_addr[k]] <= commit_i[k].rob_idx;
                end
            end
        end
    end

    // Pointers and count, full list has tail equal to head
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            head  <= '0;
            tail  <= '0;
            count <= `CNT_W'(`ROB_DEPTH);
        end else if (flush_i) begin
            head  <= '0;
            tail  <= '0;
            count <= `CNT_W'(`ROB_DEPTH);
        end else begin
            head  <= head + grant_cnt[`ROB_AW-1:0];
            tail  <= tail + commit_cnt[`ROB_AW-1:0];
            count <= count + commit_cnt - grant_cnt;
        end
    end

endmodule

`default_nettype wire

// File: src/rename_pkg.sv
`default_nettype none

`include "rename_macros.svh"

package rename_pkg;

    // ======================================================================
    // Per-slot records
    // ======================================================================

    // One decoded instruction entering rename
    typedef struct packed {
        logic                valid;
        logic [`ARCH_AW-1:0] rs1;
        logic [`ARCH_AW-1:0] rs2;
        logic [`ARCH_AW-1:0] rd;
        logic                rd_we;
    } decode_slot_t;

    // Rename result, tags read zero when the slot is not accepted
    typedef struct packed {
        logic                valid;
        logic [`PHYS_AW-1:0] rs1_phys;
        logic [`PHYS_AW-1:0] rs2_phys;
        logic [`PHYS_AW-1:0] rd_phys;
        logic [`PHYS_AW-1:0] old_rd_phys;
    } rename_slot_t;

    // One retiring ROB entry
    typedef struct packed {
        logic                valid;
        logic [`ARCH_AW-1:0] arch;
        logic [`ROB_AW-1:0]  rob_idx;
    } commit_slot_t;

    // ======================================================================
    // Groups, slot 0 is the oldest
    // ======================================================================
    typedef decode_slot_t [`RENAME_WIDTH-1:0] decode_group_t;
    typedef rename_slot_t [`RENAME_WIDTH-1:0] rename_group_t;
    typedef commit_slot_t [`RENAME_WIDTH-1:0] commit_group_t;

endpackage

`default_nettype wire

// File: include/rename_macros.svh
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// ======================================================================
// Rename stage sizing
// ======================================================================

// Architectural register file
`define ARCH_REGS     32
`define ARCH_AW       5

// Physical tag, low half is the register file and high half the ROB
`define PHYS_AW       6

// Reorder buffer entries handed out by the free list
`define ROB_DEPTH     32
`define ROB_AW        5
`define ROB_TAG_BASE  32

// Slots renamed per cycle
`define RENAME_WIDTH  3

// Free count must be able to hold ROB_DEPTH
`define CNT_W         6

`endif
